//--- fxp_mul_pkg.sv
package fxp_mul_pkg;

    // Q8.7 operand format
    localparam int FRAC_BITS = 7;

    // Half-up rounding constant sits at this bit
    localparam int ROUND_BIT = 6;

    // Radix-4 steps for a 16-bit multiplier
    localparam int BOOTH_STEPS = 8;

    // Input FIFO depth, also the producer credit count after reset
    localparam int IN_DEPTH = 4;

    // Result FIFO depth and consumer credits after reset
    localparam int OUT_DEPTH = 2;
    localparam int OUT_CREDITS = 2;

    typedef logic signed [15:0] fxp_t;
    typedef logic signed [31:0] prod_t;
    typedef logic [2:0] credit_t;

    typedef struct packed {
        fxp_t multiplicand;
        fxp_t multiplier;
    } mul_req_t;

    typedef struct packed {
        fxp_t result;
        logic overflow;
    } mul_rsp_t;

endpackage

//--- fxp_in_queue.sv
`timescale 1ns/1ps

module fxp_in_queue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  fxp_mul_pkg::mul_req_t in_req,
    output logic                  in_credit,
    output logic                  q_valid,
    output fxp_mul_pkg::mul_req_t q_req,
    input  logic                  core_ready
);

    typedef logic [$clog2(fxp_mul_pkg::IN_DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(fxp_mul_pkg::IN_DEPTH+1)-1:0] cnt_t;

    fxp_mul_pkg::mul_req_t mem [fxp_mul_pkg::IN_DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    logic pop;

    // Head of queue is always presented to the core
    assign q_valid = (count != '0);
    assign q_req = mem[rd_ptr];
    assign pop = q_valid && core_ready;

    // One credit back to the producer per entry handed on
    assign in_credit = pop;

    // Storage
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Producer credits keep the queue from overflowing
            case ({in_valid, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- booth_r4_core.sv
`timescale 1ns/1ps

module booth_r4_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  q_valid,
    input  fxp_mul_pkg::mul_req_t q_req,
    output logic                  core_ready,
    output logic                  prod_valid,
    output fxp_mul_pkg::prod_t    prod,
    input  logic                  prod_ready
);

    typedef logic [$clog2(fxp_mul_pkg::BOOTH_STEPS)-1:0] step_t;

    fxp_mul_pkg::mul_req_t req_r;

    logic        load_pend;
    logic        busy;
    step_t       step_cnt;
    logic        accept;
    logic        last_step;

    // Partial product plus multiplier with the appended zero
    logic [17:0] a_reg;
    logic [16:0] q_reg;

    logic [17:0] m_one;
    logic [17:0] m_two;
    logic [17:0] addend;
    logic [17:0] sum;

    // Idle means nothing pending, iterating or waiting for handoff
    assign core_ready = !load_pend && !busy && !prod_valid;
    assign accept = q_valid && core_ready;
    assign last_step = (step_cnt == step_t'(fxp_mul_pkg::BOOTH_STEPS - 1));

    assign m_one = {{2{req_r.multiplicand[15]}}, req_r.multiplicand};
    assign m_two = {req_r.multiplicand[15], req_r.multiplicand, 1'b0};

    // Booth recoding of the low three multiplier bits
    always_comb begin
        case (q_reg[2:0])
            3'b001, 3'b010: addend = m_one;
            3'b011:         addend = m_two;
            3'b100:         addend = -m_two;
            3'b101, 3'b110: addend = -m_one;
            default:        addend = '0;
        endcase
    end

    assign sum = a_reg + addend;

    // Upper sign bits of a_reg are redundant once done
    assign prod = {a_reg[15:0], q_reg[16:1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            load_pend <= 1'b0;
            busy <= 1'b0;
            prod_valid <= 1'b0;
            step_cnt <= '0;
        end else begin
            if (accept) begin
                load_pend <= 1'b1;
            end
            if (load_pend) begin
                load_pend <= 1'b0;
                busy <= 1'b1;
                step_cnt <= '0;
            end
            if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (last_step) begin
                    busy <= 1'b0;
                    prod_valid <= 1'b1;
                end
            end
            if (prod_valid && prod_ready) begin
                prod_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_r <= q_req;
        end
        if (load_pend) begin
            a_reg <= '0;
            q_reg <= {req_r.multiplier, 1'b0};
        end else if (busy) begin
            // Arithmetic shift of {A, Q} by two
            a_reg <= {{2{sum[17]}}, sum[17:2]};
            q_reg <= {sum[1:0], q_reg[16:2]};
        end
    end

endmodule

//--- fxp_round_out.sv
`timescale 1ns/1ps

module fxp_round_out (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  prod_valid,
    input  fxp_mul_pkg::prod_t    prod,
    output logic                  prod_ready,
    output logic                  out_valid,
    output fxp_mul_pkg::mul_rsp_t out_rsp,
    input  logic                  out_credit
);

    typedef logic [$clog2(fxp_mul_pkg::OUT_DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(fxp_mul_pkg::OUT_DEPTH+1)-1:0] cnt_t;

    fxp_mul_pkg::mul_rsp_t mem [fxp_mul_pkg::OUT_DEPTH];

    ptr_t                  wr_ptr;
    ptr_t                  rd_ptr;
    cnt_t                  count;
    fxp_mul_pkg::credit_t  credits;
    fxp_mul_pkg::prod_t    rounded;
    logic [9:0]            top_bits;
    fxp_mul_pkg::mul_rsp_t rsp_in;
    logic                  push;

    assign prod_ready = (count != cnt_t'(fxp_mul_pkg::OUT_DEPTH));
    assign push = prod_valid && prod_ready;

    // Half-up rounding, then drop the low fraction bits
    assign rounded = prod + fxp_mul_pkg::prod_t'(32'd1 << fxp_mul_pkg::ROUND_BIT);
    assign top_bits = rounded[31:fxp_mul_pkg::FRAC_BITS+15];

    // Result wraps, only the flag tells
    assign rsp_in.result = rounded[fxp_mul_pkg::FRAC_BITS +: 16];
    assign rsp_in.overflow = !((&top_bits) || !(|top_bits));

    // Send only with a consumer credit in hand
    assign out_valid = (count != '0) && (credits != '0);
    assign out_rsp = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rsp_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            credits <= fxp_mul_pkg::credit_t'(fxp_mul_pkg::OUT_CREDITS);
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (out_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, out_valid})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            // Send and returned credit in one cycle cancel out
            case ({out_valid, out_credit})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

//--- fxp_mul_top.sv
`timescale 1ns/1ps

module fxp_mul_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  fxp_mul_pkg::mul_req_t in_req,
    output logic                  in_credit,
    output logic                  out_valid,
    output fxp_mul_pkg::mul_rsp_t out_rsp,
    input  logic                  out_credit
);

    logic                  q_valid;
    fxp_mul_pkg::mul_req_t q_req;
    logic                  core_ready;
    logic                  prod_valid;
    fxp_mul_pkg::prod_t    prod;
    logic                  prod_ready;

    fxp_in_queue u_in_queue (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_credit  (in_credit),
        .q_valid    (q_valid),
        .q_req      (q_req),
        .core_ready (core_ready)
    );

    booth_r4_core u_core (
        .clk        (clk),
        .rst        (rst),
        .q_valid    (q_valid),
        .q_req      (q_req),
        .core_ready (core_ready),
        .prod_valid (prod_valid),
        .prod       (prod),
        .prod_ready (prod_ready)
    );

    fxp_round_out u_round_out (
        .clk        (clk),
        .rst        (rst),
        .prod_valid (prod_valid),
        .prod       (prod),
        .prod_ready (prod_ready),
        .out_valid  (out_valid),
        .out_rsp    (out_rsp),
        .out_credit (out_credit)
    );

endmodule

//--- fxp_mul_tb.sv
`timescale 1ns/1ps

module fxp_mul_tb;

    localparam int NUM_DIRECTED = 16;
    localparam int NUM_RANDOM = 200;
    // About 12 cycles per item, four times over
    localparam int MAX_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 12 * 4;
    localparam int DRIVE_DELAY = 1;
    localparam logic [31:0] SEED = 32'h6626;

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    fxp_mul_pkg::mul_req_t in_req;
    logic                  in_credit;
    logic                  out_valid;
    fxp_mul_pkg::mul_rsp_t out_rsp;
    logic                  out_credit;

    fxp_mul_pkg::credit_t  prod_credits;
    fxp_mul_pkg::credit_t  out_credits_model;
    fxp_mul_pkg::mul_req_t stim[$];
    fxp_mul_pkg::mul_rsp_t sb[$];
    fxp_mul_pkg::mul_rsp_t exp_rsp;
    logic [31:0]           lfsr;
    logic                  sent_any;
    int                    sent = 0;
    int                    received = 0;
    int                    returned = 0;
    int                    cycles = 0;
    int                    data_errors = 0;
    int                    protocol_errors = 0;

    fxp_mul_top dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_rsp    (out_rsp),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic int pick_stall();
        // Now and then a long stall
        if (rand_bits(4) == 32'd0) begin
            return 30 + int'(rand_bits(5));
        end
        return int'(rand_bits(2));
    endfunction

    // Q8.7 product, half-up rounded, bits 22 to 7 kept
    function automatic fxp_mul_pkg::mul_rsp_t expected_rsp(input fxp_mul_pkg::mul_req_t req);
        int a;
        int b;
        int rounded;
        int upper;
        fxp_mul_pkg::mul_rsp_t rsp;
        a = req.multiplicand;
        b = req.multiplier;
        rounded = a * b + 2 ** fxp_mul_pkg::ROUND_BIT;
        upper = rounded >>> (fxp_mul_pkg::FRAC_BITS + 15);
        rsp.result = fxp_mul_pkg::fxp_t'(rounded >>> fxp_mul_pkg::FRAC_BITS);
        rsp.overflow = (upper != 0) && (upper != -1);
        return rsp;
    endfunction

    task automatic add_pair(input int a, input int b);
        fxp_mul_pkg::mul_req_t r;
        r.multiplicand = fxp_mul_pkg::fxp_t'(a);
        r.multiplier = fxp_mul_pkg::fxp_t'(b);
        stim.push_back(r);
    endtask

    task automatic build_stimulus();
        fxp_mul_pkg::fxp_t a;
        fxp_mul_pkg::fxp_t b;
        add_pair(0, 12345);
        add_pair(128, 128);
        add_pair(-128, 300);
        add_pair(32767, 128);
        add_pair(-32768, 128);
        add_pair(32767, -128);
        add_pair(-200, 350);
        add_pair(-128, -128);
        // Low seven product bits of 64, 63 and 65
        add_pair(1, 64);
        add_pair(1, 63);
        add_pair(1, 65);
        add_pair(-1, 64);
        add_pair(-1, 65);
        add_pair(32767, 32767);
        add_pair(-32768, -32768);
        add_pair(32767, -32768);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            a = fxp_mul_pkg::fxp_t'(rand_bits(16));
            b = fxp_mul_pkg::fxp_t'(rand_bits(16));
            // Half the pairs scaled down to stay in range
            if (rand_bits(1) == 32'd1) begin
                a = a >>> 5;
                b = b >>> 4;
            end
            add_pair(a, b);
        end
    endtask

    task automatic send_pair(input fxp_mul_pkg::mul_req_t req);
        while (prod_credits == '0) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        in_valid = 1'b1;
        in_req = req;
        sent_any = 1'b1;
        sb.push_back(expected_rsp(req));
        sent++;
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid = 1'b0;
    endtask

    // Credit models track what the DUT registers hold
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rst) begin
            prod_credits <= fxp_mul_pkg::credit_t'(fxp_mul_pkg::IN_DEPTH);
            out_credits_model <= fxp_mul_pkg::credit_t'(fxp_mul_pkg::OUT_CREDITS);
        end else begin
            prod_credits <= prod_credits - fxp_mul_pkg::credit_t'(in_valid)
                + fxp_mul_pkg::credit_t'(in_credit);
            out_credits_model <= out_credits_model - fxp_mul_pkg::credit_t'(out_valid)
                + fxp_mul_pkg::credit_t'(out_credit);
        end
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d results back",
                cycles, received, sent);
            $display("Some tests failed");
            $finish;
        end
    end

    assert property (@(negedge clk) disable iff (rst)
        out_valid |-> out_credits_model != '0)
    else begin
        protocol_errors++;
        $display("[ERROR] %0t: out_valid while the DUT holds no consumer credit", $time);
    end

    assert property (@(negedge clk) disable iff (rst)
        prod_credits <= fxp_mul_pkg::credit_t'(fxp_mul_pkg::IN_DEPTH))
    else begin
        protocol_errors++;
        $display("[ERROR] %0t: producer credit count %0d out of range", $time, prod_credits);
    end

    assert property (@(negedge clk) disable iff (rst)
        !sent_any |-> (!in_credit && !out_valid))
    else begin
        protocol_errors++;
        $display("[ERROR] %0t: in_credit or out_valid high before any item", $time);
    end

    // Scoreboard, in order
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            assert (sb.size() != 0) else begin
                protocol_errors++;
                $display("[ERROR] %0t: result arrived with no item outstanding", $time);
            end
            if (sb.size() != 0) begin
                exp_rsp = sb.pop_front();
                received++;
                assert (out_rsp == exp_rsp) else begin
                    data_errors++;
                    $display("[ERROR] %0t: result %0d ovf %b, expected %0d ovf %b", $time,
                        out_rsp.result, out_rsp.overflow, exp_rsp.result, exp_rsp.overflow);
                end
            end
        end
    end

    // Consumer hands back one credit per result, after a delay
    initial begin
        int stall;
        out_credit = 1'b0;
        stall = 60;
        @(negedge rst);
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            out_credit = 1'b0;
            if (stall > 0) begin
                stall--;
            end else if (returned < received) begin
                out_credit = 1'b1;
                returned++;
                stall = pick_stall();
            end
        end
    end

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        in_req = '0;
        sent_any = 1'b0;
        lfsr = SEED;
        build_stimulus();
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        // A few idle cycles after reset before the first item
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        foreach (stim[i]) begin
            send_pair(stim[i]);
        end
        while (received < sent) begin
            @(posedge clk);
        end
        repeat (30) @(posedge clk);
        assert (prod_credits == fxp_mul_pkg::credit_t'(fxp_mul_pkg::IN_DEPTH)) else begin
            protocol_errors++;
            $display("[ERROR] %0t: producer holds %0d credits at the end", $time, prod_credits);
        end
        assert (sb.size() == 0 && received == NUM_DIRECTED + NUM_RANDOM) else begin
            protocol_errors++;
            $display("[ERROR] %0t: %0d of %0d results received", $time, received, sent);
        end
        $display("Errors: %0d data, %0d protocol", data_errors, protocol_errors);
        if (data_errors == 0 && protocol_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- fxp_booth_mul.f
fxp_mul_pkg.sv
fxp_in_queue.sv
booth_r4_core.sv
fxp_round_out.sv
fxp_mul_top.sv
fxp_mul_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f fxp_booth_mul.f \
    --top-module fxp_mul_tb \
    -o fxp_mul_sim

sim_out=$(./obj_dir/fxp_mul_sim)
echo "$sim_out"

if echo "$sim_out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
